/* rtl/gps_pkg.sv */
////////////////////////////////////////
// GPS tracking channel definitions
// APB register map, datapath widths and C/A code constants
////////////////////////////////////////
package gps_pkg;

    ////////////////////////////////////////
    // Register map, byte offsets on APB

    // G2 initial state selects the satellite
    localparam logic [7:0] reg_sv_sel    = 8'h00;
    // Carrier and code NCO rates
    localparam logic [7:0] reg_lo_rate   = 8'h04;
    localparam logic [7:0] reg_ca_rate   = 8'h08;
    // Write only, any value pauses the code NCO
    localparam logic [7:0] reg_pause     = 8'h0C;
    // Read only status
    localparam logic [7:0] reg_replica   = 8'h10;
    localparam logic [7:0] reg_epochs    = 8'h14;
    // First of six dump words: ip, qp, ie, qe, il, ql
    localparam logic [7:0] reg_dump_base = 8'h20;

    ////////////////////////////////////////
    // Datapath widths

    // Integrator width, default for the top level
    localparam int acc_w = 16;
    // Phase accumulator width of both NCOs
    localparam int nco_w = 32;

    ////////////////////////////////////////
    // Code constants

    // Chips per C/A epoch
    localparam int code_len = 1023;
    // Early, prompt and late replicas
    localparam int num_taps = 3;
    // I and Q per tap
    localparam int num_acc  = 6;

    // Index of one dump word
    typedef logic [2:0] dump_sel_t;

endpackage

/* rtl/chan_regs.sv */
`timescale 1ns/10ps
////////////////////////////////////////
// Channel register block
// APB slave holding tracking settings, muxes status
// and latched dump words onto read data
////////////////////////////////////////
module chan_regs import gps_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic [15:0] replica,
    input  logic [15:0] epoch_count,
    input  logic [31:0] dump_word,
    output logic [9:0]  g2_init,
    output logic [31:0] lo_rate,
    output logic [31:0] ca_rate,
    output logic        pause_req,
    output dump_sel_t   dump_sel
);

    typedef enum logic [2:0] {
        idx_none,
        idx_sv_sel,
        idx_lo_rate,
        idx_ca_rate,
        idx_pause,
        idx_replica,
        idx_epochs,
        idx_dump
    } reg_idx_t;

    // One past the last dump word
    localparam logic [7:0] dump_end = reg_dump_base + 8'(4 * num_acc);

    reg_idx_t   idx;
    logic [7:0] dump_off;
    logic       access;
    logic       read_only;
    logic       bad;
    logic       wr_ok;
    logic       rd_ok;

    ////////////////////////////////////////
    // Address decode

    // Unaligned addresses never hit a register
    always_comb begin
        idx = idx_none;
        if (paddr[1:0] == 2'b00) begin
            case (paddr)
                reg_sv_sel:  idx = idx_sv_sel;
                reg_lo_rate: idx = idx_lo_rate;
                reg_ca_rate: idx = idx_ca_rate;
                reg_pause:   idx = idx_pause;
                reg_replica: idx = idx_replica;
                reg_epochs:  idx = idx_epochs;
                default: begin
                    if (paddr >= reg_dump_base && paddr < dump_end)
                        idx = idx_dump;
                end
            endcase
        end
    end

    assign dump_off = paddr - reg_dump_base;
    // Word index into the dump bank, held at zero off the dump window
    assign dump_sel = (idx == idx_dump) ? dump_off[4:2] : '0;

    ////////////////////////////////////////
    // Access phase and error response

    assign access    = psel & penable;
    assign read_only = (idx == idx_replica) || (idx == idx_epochs) || (idx == idx_dump);
    assign bad       = (idx == idx_none) || (pwrite && read_only) ||
                       (!pwrite && idx == idx_pause);

    // Zero wait state slave
    assign pready  = 1'b1;
    assign pslverr = access & bad;
    assign wr_ok   = access & pwrite & ~bad;
    assign rd_ok   = access & ~pwrite & ~bad;

    // Pause is a strobe, acted on by the code NCO at the closing edge
    assign pause_req = wr_ok && (idx == idx_pause);

    // Settings registers
    always_ff @(posedge clk) begin
        if (rst) begin
            g2_init <= '0;
            lo_rate <= '0;
            ca_rate <= '0;
        end else if (wr_ok) begin
            case (idx)
                idx_sv_sel:  g2_init <= pwdata[9:0];
                idx_lo_rate: lo_rate <= pwdata;
                idx_ca_rate: ca_rate <= pwdata;
                default: ;
            endcase
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (rd_ok) begin
            case (idx)
                idx_sv_sel:  prdata = {22'h0, g2_init};
                idx_lo_rate: prdata = lo_rate;
                idx_ca_rate: prdata = ca_rate;
                idx_replica: prdata = {16'h0, replica};
                idx_epochs:  prdata = {16'h0, epoch_count};
                idx_dump:    prdata = dump_word;
                default:     prdata = '0;
            endcase
        end
    end

    // APB requires psel for the whole transfer
    a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

/* rtl/code_nco.sv */
`timescale 1ns/10ps
////////////////////////////////////////
// Code NCO
// Phase accumulator giving half-chip and full-chip
// strobes, with pause until resume
////////////////////////////////////////
module code_nco import gps_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [nco_w-1:0] ca_rate,
    input  logic             pause_req,
    input  logic             ca_resume,
    output logic             half_chip,
    output logic             full_chip,
    output logic [31:26]     code_phase
);

    logic [nco_w-1:0] phase;
    logic [nco_w-2:0] low_sum;
    logic             low_carry;
    logic             top_sum;
    logic             top_carry;
    logic             en;

    // Low bits carry out at every half chip, top bit at every full chip
    always_comb begin
        {low_carry, low_sum} = {1'b0, phase[nco_w-2:0]} + {1'b0, ca_rate[nco_w-2:0]};
        {top_carry, top_sum} = {1'b0, phase[nco_w-1]} + {1'b0, ca_rate[nco_w-1]} +
                               {1'b0, low_carry};
    end

    // Strobes only while running so a paused code stays frozen
    assign half_chip = en & low_carry;
    assign full_chip = en & low_carry & top_carry;

    // Pause holds off until the satellite lines up, then resume
    always_ff @(posedge clk) begin
        if (rst)
            en <= 1'b1;
        else if (pause_req)
            en <= 1'b0;
        else if (ca_resume)
            en <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst)
            phase <= '0;
        else if (en)
            phase <= {top_sum, low_sum};
    end

    // Fractional chip phase for the replica
    assign code_phase = phase[nco_w-1:nco_w-6];

    // A half chip that is not a chip boundary leaves the phase in its upper half
    a_mid_chip_msb: assert property (@(posedge clk) disable iff (rst)
        (half_chip && !full_chip) |=> phase[nco_w-1]);

endmodule

/* rtl/ca_code_gen.sv */
`timescale 1ns/10ps
////////////////////////////////////////
// C/A code generator
// G1/G2 Gold code with early, prompt and late
// taps half a chip apart, plus epoch flag
////////////////////////////////////////
module ca_code_gen import gps_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic [9:0]   g2_init,
    input  logic         half_chip,
    input  logic         full_chip,
    input  logic [31:26] code_phase,
    output logic         chip_e,
    output logic         chip_p,
    output logic         chip_l,
    output logic         epoch,
    output logic [15:0]  replica
);

    localparam int idx_w = $clog2(code_len);

    logic [10:1]      g1;
    logic [10:1]      g2;
    logic [10:1]      g1_nxt;
    logic [10:1]      g2_nxt;
    logic [10:1]      g1_p;
    logic [idx_w-1:0] chip_idx;
    logic             mid_chip;

    ////////////////////////////////////////
    // Early code, G1 and G2 registers

    // G1 taps 3,10; G2 taps 2,3,6,8,9,10
    always_comb begin
        g1_nxt = {g1[9:1], g1[3] ^ g1[10]};
        g2_nxt = {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            g1 <= '1;
            g2 <= '1;
        end else if (full_chip) begin
            g1 <= g1_nxt;
            // PRN selected by the G2 state at the start of each epoch
            g2 <= (&g1_nxt) ? g2_init : g2_nxt;
        end
    end

    assign chip_e = g1[10] ^ g2[10];

    ////////////////////////////////////////
    // Prompt and late stagger

    // Half chip that is not a chip boundary
    assign mid_chip = half_chip & ~full_chip;

    always_ff @(posedge clk) begin
        if (rst) begin
            chip_p <= 1'b0;
            chip_l <= 1'b0;
            g1_p   <= '1;
            epoch  <= 1'b0;
        end else begin
            // Epoch marks prompt loading the all-ones G1 state
            epoch <= mid_chip & (&g1);
            if (mid_chip) begin
                chip_p <= chip_e;
                g1_p   <= g1;
            end
            if (full_chip)
                chip_l <= chip_p;
        end
    end

    // Code phase replica for the host
    assign replica = {~code_phase[31], code_phase[30:26], g1_p};

    // Early chip count within the epoch
    always_ff @(posedge clk) begin
        if (rst)
            chip_idx <= '0;
        else if (full_chip)
            chip_idx <= (&g1_nxt) ? '0 : chip_idx + 1'b1;
    end

    // G1 must wrap to all ones exactly once per code period
    a_g1_period: assert property (@(posedge clk) disable iff (rst)
        (full_chip && (&g1_nxt)) |-> (chip_idx == idx_w'(code_len - 1)));

endmodule

/* rtl/iq_correlator.sv */
`timescale 1ns/10ps
////////////////////////////////////////
// IQ correlator
// Carrier NCO, quadrature LO, six mixers and six
// integrate-and-dump accumulators
////////////////////////////////////////
module iq_correlator import gps_pkg::*; #(
    parameter int acc_width = acc_w
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample,
    input  logic [nco_w-1:0]     lo_rate,
    input  logic                 chip_e,
    input  logic                 chip_p,
    input  logic                 chip_l,
    input  logic                 epoch,
    output logic [acc_width-1:0] ip,
    output logic [acc_width-1:0] qp,
    output logic [acc_width-1:0] ie,
    output logic [acc_width-1:0] qe,
    output logic [acc_width-1:0] il,
    output logic [acc_width-1:0] ql,
    output logic                 dump
);

    // LO bit per carrier quadrant, indexed by phase MSBs
    localparam logic [3:0] lo_sin = 4'b1100;
    localparam logic [3:0] lo_cos = 4'b0110;

    logic [nco_w-1:0]     lo_phase;
    logic                 lo_i;
    logic                 lo_q;
    logic [num_taps-1:0]  chips;
    logic [acc_width-1:0] acc_i [num_taps];
    logic [acc_width-1:0] acc_q [num_taps];

    ////////////////////////////////////////
    // Carrier NCO and quadrature LO

    always_ff @(posedge clk) begin
        if (rst)
            lo_phase <= '0;
        else
            lo_phase <= lo_phase + lo_rate;
    end

    assign lo_i = lo_sin[lo_phase[nco_w-1 -: 2]];
    assign lo_q = lo_cos[lo_phase[nco_w-1 -: 2]];

    // Dump lags epoch by one cycle
    always_ff @(posedge clk) begin
        if (rst)
            dump <= 1'b0;
        else
            dump <= epoch;
    end

    ////////////////////////////////////////
    // Mixers and integrators, one pair per tap

    // Tap 0 early, 1 prompt, 2 late
    assign chips = {chip_l, chip_p, chip_e};

    for (genvar t = 0; t < num_taps; t++) begin : g_tap
        logic                 mix_i;
        logic                 mix_q;
        logic [acc_width-1:0] sum_i;
        logic [acc_width-1:0] sum_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                mix_i <= 1'b0;
                mix_q <= 1'b0;
                sum_i <= '0;
                sum_q <= '0;
            end else begin
                // One-bit multiply by XOR
                mix_i <= sample ^ chips[t] ^ lo_i;
                mix_q <= sample ^ chips[t] ^ lo_q;
                // Bit 0 counts +1, bit 1 counts -1; restart at dump
                sum_i <= (dump ? '0 : sum_i) + (mix_i ? '1 : acc_width'(1));
                sum_q <= (dump ? '0 : sum_q) + (mix_q ? '1 : acc_width'(1));
            end
        end

        assign acc_i[t] = sum_i;
        assign acc_q[t] = sum_q;
    end

    assign ie = acc_i[0];
    assign qe = acc_q[0];
    assign ip = acc_i[1];
    assign qp = acc_q[1];
    assign il = acc_i[2];
    assign ql = acc_q[2];

    // Epoch is a single-cycle pulse, so each epoch restarts the integrators once
    a_dump_pulse: assert property (@(posedge clk) disable iff (rst) dump |-> !epoch);

endmodule

/* rtl/dump_bank.sv */
`timescale 1ns/10ps
////////////////////////////////////////
// Dump bank
// Holds one coherent epoch of IQ sums and counts epochs
////////////////////////////////////////
module dump_bank import gps_pkg::*; #(
    parameter int acc_width = acc_w
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dump,
    input  logic [acc_width-1:0] ip,
    input  logic [acc_width-1:0] qp,
    input  logic [acc_width-1:0] ie,
    input  logic [acc_width-1:0] qe,
    input  logic [acc_width-1:0] il,
    input  logic [acc_width-1:0] ql,
    input  dump_sel_t            dump_sel,
    output logic [31:0]          dump_word,
    output logic [15:0]          epoch_count
);

    logic [acc_width-1:0] bank [num_acc];
    logic [acc_width-1:0] sel_word;

    // Capture all six sums on the same edge, order matches the register map
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < num_acc; k++)
                bank[k] <= '0;
            epoch_count <= '0;
        end else if (dump) begin
            bank[0] <= ip;
            bank[1] <= qp;
            bank[2] <= ie;
            bank[3] <= qe;
            bank[4] <= il;
            bank[5] <= ql;
            // Wraps at 2^16
            epoch_count <= epoch_count + 16'd1;
        end
    end

    // Selected word, sign extended to the bus
    assign sel_word  = bank[dump_sel];
    assign dump_word = {{(32 - acc_width){sel_word[acc_width-1]}}, sel_word};

    // Register decode keeps the index inside the bank
    a_sel_range: assert property (@(posedge clk) disable iff (rst) dump_sel < num_acc);

endmodule

/* rtl/gps_channel.sv */
`timescale 1ns/10ps
////////////////////////////////////////
// GPS L1 C/A tracking channel
// APB register decode, code and carrier tracking,
// correlation and epoch dump bank
////////////////////////////////////////
module gps_channel import gps_pkg::*; #(
    parameter int acc_width = acc_w
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        sample,
    input  logic        ca_resume,
    output logic        epoch_irq
);

    // Settings from decode
    logic [9:0]  g2_init;
    logic [31:0] lo_rate;
    logic [31:0] ca_rate;
    logic        pause_req;

    // Code timing
    logic         half_chip;
    logic         full_chip;
    logic [31:26] code_phase;
    logic         chip_e;
    logic         chip_p;
    logic         chip_l;
    logic         epoch;
    logic [15:0]  replica;

    // Sums and readback
    logic [acc_width-1:0] ip;
    logic [acc_width-1:0] qp;
    logic [acc_width-1:0] ie;
    logic [acc_width-1:0] qe;
    logic [acc_width-1:0] il;
    logic [acc_width-1:0] ql;
    dump_sel_t            dump_sel;
    logic [31:0]          dump_word;
    logic [15:0]          epoch_count;

    ////////////////////////////////////////
    // Decode

    chan_regs i_regs (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .replica, .epoch_count, .dump_word,
        .g2_init, .lo_rate, .ca_rate, .pause_req, .dump_sel
    );

    ////////////////////////////////////////
    // Execute

    code_nco i_code_nco (
        .clk, .rst, .ca_rate, .pause_req, .ca_resume,
        .half_chip, .full_chip, .code_phase
    );

    ca_code_gen i_ca_code (
        .clk, .rst, .g2_init, .half_chip, .full_chip, .code_phase,
        .chip_e, .chip_p, .chip_l, .epoch, .replica
    );

    // Dump pulse doubles as the host interrupt
    iq_correlator #(.acc_width(acc_width)) i_corr (
        .clk, .rst, .sample, .lo_rate, .chip_e, .chip_p, .chip_l, .epoch,
        .ip, .qp, .ie, .qe, .il, .ql, .dump(epoch_irq)
    );

    ////////////////////////////////////////
    // Result

    dump_bank #(.acc_width(acc_width)) i_dump (
        .clk, .rst, .dump(epoch_irq), .ip, .qp, .ie, .qe, .il, .ql,
        .dump_sel, .dump_word, .epoch_count
    );

endmodule

/* tests/tb_gps_channel.sv */
`timescale 1ns/10ps
////////////////////////////////////////
// GPS tracking channel testbench
// APB register checks, epoch timing, pause and resume,
// and IQ sums against a C/A reference model
////////////////////////////////////////
module tb_gps_channel import gps_pkg::*; ();

    localparam int epoch_cycles = 4 * code_len;
    localparam int epoch_limit  = 4200;
    // LO bit per step of the carrier cycle
    localparam logic [0:3] lo_flat   = 4'b0000;
    localparam logic [0:3] sin_steps = 4'b0011;
    localparam logic [0:3] cos_steps = 4'b0110;

    logic        clk;
    logic        rst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        sample;
    logic        ca_resume;
    logic        epoch_irq;

    // Check strobes, driven with the stimulus
    logic        chk_resp;
    logic        chk_rd;
    logic        exp_err;
    logic [31:0] exp_rd;
    string       chk_name;
    logic        period_on;
    logic        pause_quiet;
    logic        resume_watch;

    // Reference state kept from epoch_irq alone
    logic [15:0] epochs_seen;
    int          gap;
    logic        gap_armed;
    int          since_resume;
    int          mismatches;
    int          failures;

    gps_channel i_dut (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .sample, .ca_resume, .epoch_irq
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference counters

    always @(posedge clk) begin
        if (rst) begin
            epochs_seen <= '0;
            gap         <= 0;
            gap_armed   <= 1'b0;
        end else if (epoch_irq) begin
            epochs_seen <= epochs_seen + 16'd1;
            gap         <= 1;
            gap_armed   <= period_on;
        end else begin
            gap <= gap + 1;
        end
    end

    always @(posedge clk)
        since_resume <= resume_watch ? since_resume + 1 : 0;

    ////////////////////////////////////////
    // Checks

    a_rd_data: assert property (@(posedge clk) disable iff (rst) chk_rd |-> prdata == exp_rd)
        else begin
            mismatches++;
            $display("MISMATCH at %0t: %s prdata expected %h got %h",
                     $time, chk_name, exp_rd, $sampled(prdata));
        end

    a_resp: assert property (@(posedge clk) disable iff (rst) chk_resp |-> pslverr == exp_err)
        else begin
            mismatches++;
            $display("MISMATCH at %0t: %s pslverr expected %b got %b",
                     $time, chk_name, exp_err, $sampled(pslverr));
        end

    // Only gaps between two pulses of a steady run count
    a_epoch_gap: assert property (@(posedge clk) disable iff (rst)
        (epoch_irq && gap_armed && period_on) |-> gap == epoch_cycles)
        else begin
            mismatches++;
            $display("MISMATCH at %0t: epoch_irq gap expected %0d got %0d",
                     $time, epoch_cycles, $sampled(gap));
        end

    a_quiet: assert property (@(posedge clk) disable iff (rst) pause_quiet |-> !epoch_irq)
        else begin
            failures++;
            $display("Error at %0t: epoch_irq pulsed while the code NCO was paused", $time);
        end

    a_resume: assert property (@(posedge clk) disable iff (rst)
        (resume_watch && epoch_irq) |-> since_resume <= epoch_cycles)
        else begin
            failures++;
            $display("Error at %0t: first epoch came %0d cycles after resume",
                     $time, $sampled(since_resume));
        end

    ////////////////////////////////////////
    // C/A reference model

    // Ones in one code period, G1 all ones and G2 at the seed
    function automatic int count_code_ones(input logic [9:0] seed);
        bit g1 [1:10];
        bit g2 [1:10];
        bit fb1;
        bit fb2;
        int ones;
        ones = 0;
        for (int s = 1; s <= 10; s++) begin
            g1[s] = 1'b1;
            g2[s] = seed[s-1];
        end
        for (int n = 0; n < code_len; n++) begin
            ones += int'(g1[10] ^ g2[10]);
            fb1 = g1[3] ^ g1[10];
            fb2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
            for (int s = 10; s > 1; s--) begin
                g1[s] = g1[s-1];
                g2[s] = g2[s-1];
            end
            g1[1] = fb1;
            g2[1] = fb2;
        end
        return ones;
    endfunction

    // Four samples per chip, each chip sees all four LO steps once
    function automatic int expected_sum(input bit smp, input int ones, input logic [0:3] steps);
        int per_chip [2];
        for (int c = 0; c < 2; c++) begin
            per_chip[c] = 0;
            for (int k = 0; k < 4; k++)
                per_chip[c] += (smp ^ c[0] ^ steps[k]) ? -1 : 1;
        end
        return (code_len - ones) * per_chip[0] + ones * per_chip[1];
    endfunction

    ////////////////////////////////////////
    // APB and sequencing tasks

    // Mode 0 checks only the response, 1 the data, 2 the epoch model
    task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                            input logic err, input int mode, input logic [31:0] exp,
                            input string name, output logic [31:0] rdata);
        int waits;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable  = 1'b1;
        chk_name = name;
        exp_err  = err;
        chk_resp = 1'b1;
        chk_rd   = (mode != 0) && !wr && !err;
        exp_rd   = (mode == 2) ? {16'h0, epochs_seen} : exp;
        #1;
        waits = 0;
        while (pready !== 1'b1 && waits < 16) begin
            @(negedge clk);
            #1;
            waits++;
        end
        if (pready !== 1'b1) begin
            failures++;
            $display("Error at %0t: no pready for %s", $time, name);
        end
        rdata = prdata;
        @(negedge clk);
        psel     = 1'b0;
        penable  = 1'b0;
        chk_resp = 1'b0;
        chk_rd   = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic err);
        logic [31:0] unused;
        apb_xfer(addr, 1'b1, data, err, 0, '0, $sformatf("write %h", addr), unused);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp, input logic err,
                            input string name);
        logic [31:0] unused;
        apb_xfer(addr, 1'b0, '0, err, 1, exp, name, unused);
    endtask

    task automatic read_epochs();
        logic [31:0] unused;
        apb_xfer(reg_epochs, 1'b0, '0, 1'b0, 2, '0, "epochs", unused);
    endtask

    task automatic read_raw(input logic [7:0] addr, output logic [31:0] rdata);
        apb_xfer(addr, 1'b0, '0, 1'b0, 0, '0, "raw read", rdata);
    endtask

    // Returns once the bank holds the epoch just dumped
    task automatic wait_epoch();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (epoch_irq !== 1'b1 && n < epoch_limit);
        if (epoch_irq !== 1'b1) begin
            failures++;
            $display("Error at %0t: no epoch_irq within %0d cycles", $time, epoch_limit);
        end
        @(negedge clk);
    endtask

    // Dump words in register order ip, qp, ie, qe, il, ql
    task automatic check_bank(input bit smp, input int ones,
                              input logic [0:3] i_steps, input logic [0:3] q_steps);
        logic [31:0] exp_i;
        logic [31:0] exp_q;
        exp_i = 32'(expected_sum(smp, ones, i_steps));
        exp_q = 32'(expected_sum(smp, ones, q_steps));
        read_reg(reg_dump_base + 8'd0, exp_i, 1'b0, "ip");
        read_reg(reg_dump_base + 8'd4, exp_q, 1'b0, "qp");
        read_reg(reg_dump_base + 8'd8, exp_i, 1'b0, "ie");
        read_reg(reg_dump_base + 8'd12, exp_q, 1'b0, "qe");
        read_reg(reg_dump_base + 8'd16, exp_i, 1'b0, "il");
        read_reg(reg_dump_base + 8'd20, exp_q, 1'b0, "ql");
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    ////////////////////////////////////////
    // Stimulus

    initial begin
        logic [31:0] sv_val;
        logic [31:0] lo_val;
        logic [31:0] ca_val;
        logic [31:0] held;
        logic [9:0]  seed;
        logic [7:0]  addr;
        int          ones;
        bit          smp;
        void'($urandom(32'h595a31d3));
        rst          = 1'b1;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        sample       = 1'b0;
        ca_resume    = 1'b0;
        chk_resp     = 1'b0;
        chk_rd       = 1'b0;
        exp_err      = 1'b0;
        exp_rd       = '0;
        chk_name     = "";
        period_on    = 1'b0;
        pause_quiet  = 1'b0;
        resume_watch = 1'b0;
        mismatches   = 0;
        failures     = 0;
        @(negedge clk);
        apply_reset();

        // Settings read back, sv_sel keeps 10 bits
        sv_val = $urandom;
        write_reg(reg_sv_sel, sv_val, 1'b0);
        read_reg(reg_sv_sel, {22'h0, sv_val[9:0]}, 1'b0, "sv_sel");
        lo_val = $urandom;
        write_reg(reg_lo_rate, lo_val, 1'b0);
        read_reg(reg_lo_rate, lo_val, 1'b0, "lo_rate");
        ca_val = $urandom;
        write_reg(reg_ca_rate, ca_val, 1'b0);
        read_reg(reg_ca_rate, ca_val, 1'b0, "ca_rate");
        // Rejected reads
        read_reg(reg_pause, '0, 1'b1, "pause read");
        repeat (4) begin
            addr = 8'($urandom_range(14, 63) << 2);
            read_reg(addr, '0, 1'b1, "unlisted read");
            addr = {6'($urandom), 2'($urandom_range(1, 3))};
            read_reg(addr, '0, 1'b1, "unaligned read");
        end
        // Rejected writes leave every setting alone
        write_reg(reg_replica, $urandom, 1'b1);
        write_reg(reg_epochs, $urandom, 1'b1);
        write_reg(8'(reg_dump_base + 4 * $urandom_range(0, num_acc - 1)), $urandom, 1'b1);
        write_reg(8'h05, $urandom, 1'b1);
        read_reg(reg_sv_sel, {22'h0, sv_val[9:0]}, 1'b0, "sv_sel");
        read_reg(reg_lo_rate, lo_val, 1'b0, "lo_rate");
        read_reg(reg_ca_rate, ca_val, 1'b0, "ca_rate");
        apply_reset();

        // Tracking setup, chip of 4 cycles
        seed = 10'($urandom);
        ones = count_code_ones(seed);
        write_reg(reg_sv_sel, {22'h0, seed}, 1'b0);
        write_reg(reg_lo_rate, '0, 1'b0);
        write_reg(reg_ca_rate, 32'h4000_0000, 1'b0);
        read_epochs();
        wait_epoch();
        wait_epoch();
        period_on = 1'b1;
        repeat (3) begin
            wait_epoch();
            read_epochs();
        end

        // Flat LO, constant samples
        check_bank(1'b0, ones, lo_flat, lo_flat);
        sample = 1'b1;
        wait_epoch();
        wait_epoch();
        check_bank(1'b1, ones, lo_flat, lo_flat);

        // Pause at a random point, well clear of the last dump
        period_on = 1'b0;
        wait_epoch();
        repeat ($urandom_range(10, 3000)) @(negedge clk);
        write_reg(reg_pause, $urandom, 1'b0);
        repeat (4) @(negedge clk);
        pause_quiet = 1'b1;
        read_raw(reg_replica, held);
        repeat ($urandom_range(200, 3000)) @(negedge clk);
        read_reg(reg_replica, held, 1'b0, "replica");
        read_epochs();
        pause_quiet  = 1'b0;
        ca_resume    = 1'b1;
        resume_watch = 1'b1;
        @(negedge clk);
        ca_resume = 1'b0;
        wait_epoch();
        resume_watch = 1'b0;

        // Quarter-rate carrier against a random sample level
        smp = 1'($urandom);
        sample = smp;
        write_reg(reg_lo_rate, 32'h4000_0000, 1'b0);
        wait_epoch();
        period_on = 1'b1;
        wait_epoch();
        wait_epoch();
        check_bank(smp, ones, sin_steps, cos_steps);
        read_epochs();

        $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* files.f */
rtl/gps_pkg.sv
rtl/chan_regs.sv
rtl/code_nco.sv
rtl/ca_code_gen.sv
rtl/iq_correlator.sv
rtl/dump_bank.sv
rtl/gps_channel.sv
tests/tb_gps_channel.sv
